//--- src/rvc_pkg.sv
package rvc_pkg;

	// ========================================================================
	// buffer and credit sizing
	// ========================================================================

	// the upstream fetch unit starts with one credit per buffer word.
	localparam int FETCH_DEPTH = 4;
	localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
	localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);

	// receive capacity of the downstream decoder.
	localparam int ISSUE_CREDITS = 2;
	localparam int ISSUE_CNT_W = $clog2(ISSUE_CREDITS + 1);

	// ========================================================================
	// RV32I field positions and opcode templates
	// ========================================================================

	localparam int unsigned RD_LSB = 7;
	localparam int unsigned RS1_LSB = 15;
	localparam int unsigned RS2_LSB = 20;

	// register and immediate fields are left at zero.
	localparam logic [31:0] OP_ADDI = 32'h0000_0013;
	localparam logic [31:0] OP_LW = 32'h0000_2003;
	localparam logic [31:0] OP_SW = 32'h0000_2023;
	localparam logic [31:0] OP_JAL = 32'h0000_006f;
	localparam logic [31:0] OP_JALR = 32'h0000_0067;
	localparam logic [31:0] OP_LUI = 32'h0000_0037;
	localparam logic [31:0] OP_SLLI = 32'h0000_1013;
	localparam logic [31:0] OP_SRLI = 32'h0000_5013;
	localparam logic [31:0] OP_SRAI = 32'h4000_5013;
	localparam logic [31:0] OP_ANDI = 32'h0000_7013;
	localparam logic [31:0] OP_ADD = 32'h0000_0033;
	localparam logic [31:0] OP_SUB = 32'h4000_0033;
	localparam logic [31:0] OP_AND = 32'h0000_7033;
	localparam logic [31:0] OP_OR = 32'h0000_6033;
	localparam logic [31:0] OP_XOR = 32'h0000_4033;
	localparam logic [31:0] OP_BEQ = 32'h0000_0063;
	localparam logic [31:0] OP_BNE = 32'h0000_1063;

	// ========================================================================
	// compressed match patterns, for casez
	// ========================================================================

	// quadrant 0.
	localparam logic [15:0] C_ADDI4SPN = 16'b000???????????00;
	localparam logic [15:0] C_LW = 16'b010???????????00;
	localparam logic [15:0] C_SW = 16'b110???????????00;

	// quadrant 1. shifts with shamt[5] set are reserved on RV32 and do not match.
	localparam logic [15:0] C_ADDI = 16'b000???????????01;
	localparam logic [15:0] C_JAL = 16'b001???????????01;
	localparam logic [15:0] C_LI = 16'b010???????????01;
	localparam logic [15:0] C_LUI = 16'b011???????????01;
	localparam logic [15:0] C_SRLI = 16'b100000????????01;
	localparam logic [15:0] C_SRAI = 16'b100001????????01;
	localparam logic [15:0] C_ANDI = 16'b100?10????????01;
	localparam logic [15:0] C_SUB = 16'b100011???00???01;
	localparam logic [15:0] C_XOR = 16'b100011???01???01;
	localparam logic [15:0] C_OR = 16'b100011???10???01;
	localparam logic [15:0] C_AND = 16'b100011???11???01;
	localparam logic [15:0] C_J = 16'b101???????????01;
	localparam logic [15:0] C_BEQZ = 16'b110???????????01;
	localparam logic [15:0] C_BNEZ = 16'b111???????????01;

	// quadrant 2.
	localparam logic [15:0] C_SLLI = 16'b0000??????????10;
	localparam logic [15:0] C_LWSP = 16'b010???????????10;
	localparam logic [15:0] C_MV = 16'b1000??????????10;
	localparam logic [15:0] C_ADD = 16'b1001??????????10;
	localparam logic [15:0] C_SWSP = 16'b110???????????10;

	// ========================================================================
	// stream and packet types
	// ========================================================================

	// lo is the earlier halfword in program order.
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} parcel_pair_t;

	// a fetch word is either one aligned 32-bit instruction or two parcels.
	typedef union packed {
		logic [31:0] word;
		parcel_pair_t half;
	} fetch_word_u;

	// instr is zero whenever invalid is set.
	typedef struct packed {
		logic [31:0] instr;
		logic is_32bit;
		logic invalid;
	} issue_pkt_t;

endpackage

//--- src/rvc_fetch_align.sv
module rvc_fetch_align (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fetch_valid,
	input  rvc_pkg::fetch_word_u fetch_word,
	input  logic                 take,
	output logic                 fetch_credit,
	output logic                 cand_valid,
	output logic [31:0]          cand_raw,
	output logic                 cand_is_32bit
);

	rvc_pkg::fetch_word_u mem [rvc_pkg::FETCH_DEPTH];

	logic [rvc_pkg::FETCH_PTR_W-1:0] wr_ptr;
	logic [rvc_pkg::FETCH_PTR_W-1:0] rd_ptr;
	logic [rvc_pkg::FETCH_PTR_W-1:0] rd_ptr_nxt;
	logic [rvc_pkg::FETCH_CNT_W-1:0] count;
	logic                            half_sel;
	rvc_pkg::fetch_word_u            cur_word;
	rvc_pkg::fetch_word_u            nxt_word;
	logic [15:0]                     low_parcel;
	logic                            two_words;
	logic                            pop;

	function automatic logic [rvc_pkg::FETCH_PTR_W-1:0] wrap_inc(
		input logic [rvc_pkg::FETCH_PTR_W-1:0] ptr
	);
		if (ptr == rvc_pkg::FETCH_PTR_W'(rvc_pkg::FETCH_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// ========================================================================
	// candidate extraction
	// ========================================================================

	assign rd_ptr_nxt = wrap_inc(rd_ptr);
	assign cur_word = mem[rd_ptr];
	assign nxt_word = mem[rd_ptr_nxt];

	// half_sel picks which halfword of the head word starts the next instruction.
	assign low_parcel = half_sel ? cur_word.half.hi : cur_word.half.lo;
	assign cand_is_32bit = (low_parcel[1:0] == 2'b11);
	assign two_words = (count > rvc_pkg::FETCH_CNT_W'(1));

	always_comb begin
		if (count == '0) begin
			cand_valid = 1'b0;
		end else if (cand_is_32bit && half_sel) begin
			// the upper half lives in the following word.
			cand_valid = two_words;
		end else begin
			cand_valid = 1'b1;
		end
	end

	// an aligned word is used whole, a straddling one is stitched together.
	assign cand_raw = half_sel ? {nxt_word.half.lo, cur_word.half.hi} : cur_word.word;

	// at most one word is retired per take, whatever the instruction width.
	assign pop = take && (half_sel || cand_is_32bit);

	// ========================================================================
	// buffer state
	// ========================================================================

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			mem[wr_ptr] <= fetch_word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			half_sel <= 1'b0;
			fetch_credit <= 1'b0;
		end else begin
			fetch_credit <= pop;
			if (fetch_valid) begin
				wr_ptr <= wrap_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= rd_ptr_nxt;
			end
			// a compressed step flips the halfword, a full step keeps it.
			if (take) begin
				half_sel <= half_sel ^ ~cand_is_32bit;
			end
			case ({fetch_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- src/rvc_decompress.sv
module rvc_decompress (
	input  logic [15:0] parcel,
	output logic [31:0] expanded,
	output logic        invalid
);

	// full register fields for cr, ci and css formats.
	logic [4:0]  rd_l;
	logic [4:0]  rs1_l;
	logic [4:0]  rs2_l;
	// three-bit fields of the other formats reach only x8 to x15.
	logic [4:0]  rd_s;
	logic [4:0]  rs1_s;
	logic [4:0]  rs2_s;

	logic [31:0] imm_ci;
	logic [31:0] shamt_i;
	logic [31:0] imm_cj;
	logic [31:0] imm_cb;

	function automatic logic [31:0] reg_at(input logic [4:0] r, input int unsigned lsb);
		return 32'(r) << lsb;
	endfunction

	assign rd_l = parcel[11:7];
	assign rs1_l = parcel[11:7];
	assign rs2_l = parcel[6:2];
	assign rd_s = {2'b01, parcel[4:2]};
	assign rs1_s = {2'b01, parcel[9:7]};
	assign rs2_s = {2'b01, parcel[4:2]};

	// ========================================================================
	// immediates, already placed in their RV32I bit positions
	// ========================================================================

	assign imm_ci = {{7{parcel[12]}}, parcel[6:2], 20'h0};
	assign shamt_i = {7'h0, parcel[6:2], 20'h0};

	// J-type offset, bits 20 and 19:12 are sign copies.
	assign imm_cj = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7], parcel[2],
		parcel[11], parcel[5:3], parcel[12], {8{parcel[12]}}, 12'h0};

	assign imm_cb = {{4{parcel[12]}}, parcel[6:5], parcel[2], 13'h0,
		parcel[11:10], parcel[4:3], parcel[12], 7'h0};

	// ========================================================================
	// expansion
	// ========================================================================

	always_comb begin
		expanded = '0;
		invalid = 1'b0;
		casez (parcel)
			16'h0000: invalid = 1'b1;
			rvc_pkg::C_ADDI4SPN: expanded = rvc_pkg::OP_ADDI | reg_at(rd_s, rvc_pkg::RD_LSB)
				| reg_at(5'd2, rvc_pkg::RS1_LSB)
				| {2'b00, parcel[10:7], parcel[12:11], parcel[5], parcel[6], 2'b00, 20'h0};
			rvc_pkg::C_LW: expanded = rvc_pkg::OP_LW | reg_at(rd_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB)
				| {5'h0, parcel[5], parcel[12:10], parcel[6], 2'b00, 20'h0};
			rvc_pkg::C_SW: expanded = rvc_pkg::OP_SW | reg_at(rs2_s, rvc_pkg::RS2_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB)
				| {5'h0, parcel[5], parcel[12], 13'h0, parcel[11:10], parcel[6], 2'b00, 7'h0};
			rvc_pkg::C_ADDI: expanded = rvc_pkg::OP_ADDI | reg_at(rd_l, rvc_pkg::RD_LSB)
				| reg_at(rs1_l, rvc_pkg::RS1_LSB) | imm_ci;
			rvc_pkg::C_JAL: expanded = rvc_pkg::OP_JAL | reg_at(5'd1, rvc_pkg::RD_LSB) | imm_cj;
			rvc_pkg::C_J: expanded = rvc_pkg::OP_JAL | imm_cj;
			rvc_pkg::C_LI: expanded = rvc_pkg::OP_ADDI | reg_at(rd_l, rvc_pkg::RD_LSB) | imm_ci;
			rvc_pkg::C_LUI: begin
				if (rd_l == 5'd2) begin
					// this is addi16sp, the stack pointer adjust.
					expanded = rvc_pkg::OP_ADDI | reg_at(5'd2, rvc_pkg::RD_LSB)
						| reg_at(5'd2, rvc_pkg::RS1_LSB)
						| {{3{parcel[12]}}, parcel[4:3], parcel[5], parcel[2], parcel[6],
						4'h0, 20'h0};
				end else begin
					expanded = rvc_pkg::OP_LUI | reg_at(rd_l, rvc_pkg::RD_LSB)
						| {{15{parcel[12]}}, parcel[6:2], 12'h0};
				end
			end
			rvc_pkg::C_SRLI: expanded = rvc_pkg::OP_SRLI | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | shamt_i;
			rvc_pkg::C_SRAI: expanded = rvc_pkg::OP_SRAI | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | shamt_i;
			rvc_pkg::C_ANDI: expanded = rvc_pkg::OP_ANDI | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | imm_ci;
			rvc_pkg::C_SUB: expanded = rvc_pkg::OP_SUB | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | reg_at(rs2_s, rvc_pkg::RS2_LSB);
			rvc_pkg::C_XOR: expanded = rvc_pkg::OP_XOR | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | reg_at(rs2_s, rvc_pkg::RS2_LSB);
			rvc_pkg::C_OR: expanded = rvc_pkg::OP_OR | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | reg_at(rs2_s, rvc_pkg::RS2_LSB);
			rvc_pkg::C_AND: expanded = rvc_pkg::OP_AND | reg_at(rs1_s, rvc_pkg::RD_LSB)
				| reg_at(rs1_s, rvc_pkg::RS1_LSB) | reg_at(rs2_s, rvc_pkg::RS2_LSB);
			rvc_pkg::C_BEQZ: expanded = rvc_pkg::OP_BEQ | reg_at(rs1_s, rvc_pkg::RS1_LSB) | imm_cb;
			rvc_pkg::C_BNEZ: expanded = rvc_pkg::OP_BNE | reg_at(rs1_s, rvc_pkg::RS1_LSB) | imm_cb;
			rvc_pkg::C_SLLI: expanded = rvc_pkg::OP_SLLI | reg_at(rs1_l, rvc_pkg::RD_LSB)
				| reg_at(rs1_l, rvc_pkg::RS1_LSB) | shamt_i;
			rvc_pkg::C_LWSP: expanded = rvc_pkg::OP_LW | reg_at(rd_l, rvc_pkg::RD_LSB)
				| reg_at(5'd2, rvc_pkg::RS1_LSB)
				| {4'h0, parcel[3:2], parcel[12], parcel[6:4], 2'b00, 20'h0};
			rvc_pkg::C_MV: begin
				if (rs2_l != 5'd0) begin
					expanded = rvc_pkg::OP_ADD | reg_at(rd_l, rvc_pkg::RD_LSB)
						| reg_at(rs2_l, rvc_pkg::RS2_LSB);
				end else begin
					// c.jr, jump without link.
					expanded = rvc_pkg::OP_JALR | reg_at(rs1_l, rvc_pkg::RS1_LSB);
				end
			end
			rvc_pkg::C_ADD: begin
				if (rs2_l != 5'd0) begin
					expanded = rvc_pkg::OP_ADD | reg_at(rd_l, rvc_pkg::RD_LSB)
						| reg_at(rs1_l, rvc_pkg::RS1_LSB) | reg_at(rs2_l, rvc_pkg::RS2_LSB);
				end else begin
					// c.jalr links through ra.
					expanded = rvc_pkg::OP_JALR | reg_at(5'd1, rvc_pkg::RD_LSB)
						| reg_at(rs1_l, rvc_pkg::RS1_LSB);
				end
			end
			rvc_pkg::C_SWSP: expanded = rvc_pkg::OP_SW | reg_at(rs2_l, rvc_pkg::RS2_LSB)
				| reg_at(5'd2, rvc_pkg::RS1_LSB)
				| {4'h0, parcel[8:7], parcel[12], 13'h0, parcel[11:9], 2'b00, 7'h0};
			default: invalid = 1'b1;
		endcase
	end

endmodule

//--- src/rvc_issue_credit.sv
module rvc_issue_credit (
	input  logic                clk,
	input  logic                rst,
	input  logic                cand_valid,
	input  logic [31:0]         cand_raw,
	input  logic                cand_is_32bit,
	input  logic [31:0]         expanded,
	input  logic                invalid,
	input  logic                issue_credit,
	output logic                take,
	output logic                issue_valid,
	output rvc_pkg::issue_pkt_t issue_pkt
);

	logic [rvc_pkg::ISSUE_CNT_W-1:0] credits;
	rvc_pkg::issue_pkt_t             pkt_next;

	// a candidate is only accepted while the decoder has room for it.
	assign take = cand_valid && (credits != '0);

	// the decompressor also sees the low half of full-width words, so its
	// flag only counts for compressed parcels.
	always_comb begin
		pkt_next.instr = cand_is_32bit ? cand_raw : expanded;
		pkt_next.is_32bit = cand_is_32bit;
		pkt_next.invalid = !cand_is_32bit && invalid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= rvc_pkg::ISSUE_CNT_W'(rvc_pkg::ISSUE_CREDITS);
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= take;
			case ({take, issue_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			issue_pkt <= pkt_next;
		end
	end

endmodule

//--- src/rvc_frontend.sv
module rvc_frontend (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fetch_valid,
	input  rvc_pkg::fetch_word_u fetch_word,
	input  logic                 issue_credit,
	output logic                 fetch_credit,
	output logic                 issue_valid,
	output rvc_pkg::issue_pkt_t  issue_pkt
);

	logic        take;
	logic        cand_valid;
	logic [31:0] cand_raw;
	logic        cand_is_32bit;
	logic [31:0] expanded;
	logic        invalid;

	rvc_fetch_align u_align (
		.clk           (clk),
		.rst           (rst),
		.fetch_valid   (fetch_valid),
		.fetch_word    (fetch_word),
		.take          (take),
		.fetch_credit  (fetch_credit),
		.cand_valid    (cand_valid),
		.cand_raw      (cand_raw),
		.cand_is_32bit (cand_is_32bit)
	);

	// only the first parcel of a candidate can be compressed.
	rvc_decompress u_decompress (
		.parcel   (cand_raw[15:0]),
		.expanded (expanded),
		.invalid  (invalid)
	);

	rvc_issue_credit u_issue (
		.clk           (clk),
		.rst           (rst),
		.cand_valid    (cand_valid),
		.cand_raw      (cand_raw),
		.cand_is_32bit (cand_is_32bit),
		.expanded      (expanded),
		.invalid       (invalid),
		.issue_credit  (issue_credit),
		.take          (take),
		.issue_valid   (issue_valid),
		.issue_pkt     (issue_pkt)
	);

endmodule

//--- test/rvc_frontend_sva.sv
module rvc_frontend_sva (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic fetch_credit,
	input logic issue_valid,
	input logic issue_credit
);

	int outstanding;
	int accepted;
	int returned;

	always @(posedge clk) begin
		if (rst) begin
			outstanding <= 0;
			accepted <= 0;
			returned <= 0;
		end else begin
			outstanding <= outstanding + (issue_valid ? 1 : 0) - (issue_credit ? 1 : 0);
			accepted <= accepted + (fetch_valid ? 1 : 0);
			returned <= returned + (fetch_credit ? 1 : 0);
		end
	end

	// a credit returned in the cycle of the take was not yet visible to the DUT.
	a_issue_holds_credit: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> (outstanding + ($past(issue_credit) ? 1 : 0)) < rvc_pkg::ISSUE_CREDITS)
		else $error("issue_valid seen without a held issue credit");

	a_outstanding_bound: assert property (@(posedge clk) disable iff (rst)
		outstanding >= 0 && outstanding <= rvc_pkg::ISSUE_CREDITS)
		else $error("outstanding issue packets exceed the decoder capacity");

	a_fetch_credit_bound: assert property (@(posedge clk) disable iff (rst)
		returned <= accepted)
		else $error("more fetch credits returned than words accepted");

endmodule

//--- test/rvc_ref_model.svh
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// ============================================================================
// RV32I format builders
// ============================================================================

function automatic logic [31:0] fmt_i(input logic [31:0] tmpl, input logic [4:0] rd,
	input logic [4:0] rs1, input logic [11:0] imm);
	return tmpl | {imm, rs1, 3'b000, rd, 7'h0};
endfunction

function automatic logic [31:0] fmt_s(input logic [31:0] tmpl, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [11:0] imm);
	return tmpl | {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h0};
endfunction

function automatic logic [31:0] fmt_r(input logic [31:0] tmpl, input logic [4:0] rd,
	input logic [4:0] rs1, input logic [4:0] rs2);
	return tmpl | {7'h0, rs2, rs1, 3'b000, rd, 7'h0};
endfunction

function automatic logic [31:0] fmt_b(input logic [31:0] tmpl, input logic [4:0] rs1,
	input logic [12:0] imm);
	return tmpl | {imm[12], imm[10:5], 5'h0, rs1, 3'b000, imm[4:1], imm[11], 7'h0};
endfunction

function automatic logic [31:0] fmt_j(input logic [31:0] tmpl, input logic [4:0] rd,
	input logic [20:0] imm);
	return tmpl | {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h0};
endfunction

// expected packet for one compressed parcel.
function automatic rvc_pkg::issue_pkt_t model_expand(input logic [15:0] p);
	rvc_pkg::issue_pkt_t pkt;
	logic [4:0]  rl;
	logic [4:0]  r2l;
	logic [4:0]  rs;
	logic [4:0]  r2s;
	logic [11:0] simm;
	logic [20:0] joff;
	logic [12:0] boff;
	rl = p[11:7];
	r2l = p[6:2];
	rs = {2'b01, p[9:7]};
	r2s = {2'b01, p[4:2]};
	simm = {{6{p[12]}}, p[12], p[6:2]};
	joff = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
	boff = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
	pkt = '0;
	casez (p)
		16'h0000: pkt.invalid = 1'b1;
		rvc_pkg::C_ADDI4SPN: pkt.instr = fmt_i(rvc_pkg::OP_ADDI, r2s, 5'd2,
			{2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00});
		rvc_pkg::C_LW: pkt.instr = fmt_i(rvc_pkg::OP_LW, r2s, rs,
			{5'h0, p[5], p[12:10], p[6], 2'b00});
		rvc_pkg::C_SW: pkt.instr = fmt_s(rvc_pkg::OP_SW, rs, r2s,
			{5'h0, p[5], p[12:10], p[6], 2'b00});
		rvc_pkg::C_ADDI: pkt.instr = fmt_i(rvc_pkg::OP_ADDI, rl, rl, simm);
		rvc_pkg::C_JAL: pkt.instr = fmt_j(rvc_pkg::OP_JAL, 5'd1, joff);
		rvc_pkg::C_J: pkt.instr = fmt_j(rvc_pkg::OP_JAL, 5'd0, joff);
		rvc_pkg::C_LI: pkt.instr = fmt_i(rvc_pkg::OP_ADDI, rl, 5'd0, simm);
		rvc_pkg::C_LUI: pkt.instr = (rl == 5'd2) ? fmt_i(rvc_pkg::OP_ADDI, 5'd2, 5'd2,
			{{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'h0})
			: (rvc_pkg::OP_LUI | {{14{p[12]}}, p[12], p[6:2], rl, 7'h0});
		rvc_pkg::C_SRLI: pkt.instr = fmt_i(rvc_pkg::OP_SRLI, rs, rs, {7'h0, p[6:2]});
		rvc_pkg::C_SRAI: pkt.instr = fmt_i(rvc_pkg::OP_SRAI, rs, rs, {7'h0, p[6:2]});
		rvc_pkg::C_ANDI: pkt.instr = fmt_i(rvc_pkg::OP_ANDI, rs, rs, simm);
		rvc_pkg::C_SUB: pkt.instr = fmt_r(rvc_pkg::OP_SUB, rs, rs, r2s);
		rvc_pkg::C_XOR: pkt.instr = fmt_r(rvc_pkg::OP_XOR, rs, rs, r2s);
		rvc_pkg::C_OR: pkt.instr = fmt_r(rvc_pkg::OP_OR, rs, rs, r2s);
		rvc_pkg::C_AND: pkt.instr = fmt_r(rvc_pkg::OP_AND, rs, rs, r2s);
		rvc_pkg::C_BEQZ: pkt.instr = fmt_b(rvc_pkg::OP_BEQ, rs, boff);
		rvc_pkg::C_BNEZ: pkt.instr = fmt_b(rvc_pkg::OP_BNE, rs, boff);
		rvc_pkg::C_SLLI: pkt.instr = fmt_i(rvc_pkg::OP_SLLI, rl, rl, {7'h0, p[6:2]});
		rvc_pkg::C_LWSP: pkt.instr = fmt_i(rvc_pkg::OP_LW, rl, 5'd2,
			{4'h0, p[3:2], p[12], p[6:4], 2'b00});
		rvc_pkg::C_MV: pkt.instr = (r2l != 5'd0) ? fmt_r(rvc_pkg::OP_ADD, rl, 5'd0, r2l)
			: fmt_i(rvc_pkg::OP_JALR, 5'd0, rl, 12'h0);
		rvc_pkg::C_ADD: pkt.instr = (r2l != 5'd0) ? fmt_r(rvc_pkg::OP_ADD, rl, rl, r2l)
			: fmt_i(rvc_pkg::OP_JALR, 5'd1, rl, 12'h0);
		rvc_pkg::C_SWSP: pkt.instr = fmt_s(rvc_pkg::OP_SW, 5'd2, r2l,
			{4'h0, p[8:7], p[12:9], 2'b00});
		default: pkt.invalid = 1'b1;
	endcase
	return pkt;
endfunction

// program halfwords go in order, lo half first.
task automatic add_wide(input logic [31:0] w, input string name);
	prog_q.push_back(w[15:0]);
	prog_q.push_back(w[31:16]);
	exp_q.push_back({w, 1'b1, 1'b0});
	name_q.push_back(name);
endtask

task automatic add_short(input logic [15:0] p, input string name);
	prog_q.push_back(p);
	exp_q.push_back(model_expand(p));
	name_q.push_back(name);
endtask

`endif

//--- test/rvc_frontend_tb.sv
module rvc_frontend_tb;

	logic                 clk;
	logic                 rst;
	logic                 fetch_valid;
	rvc_pkg::fetch_word_u fetch_word;
	logic                 issue_credit;
	logic                 fetch_credit;
	logic                 issue_valid;
	rvc_pkg::issue_pkt_t  issue_pkt;

	logic [15:0]          prog_q[$];
	rvc_pkg::issue_pkt_t  exp_q[$];
	string                name_q[$];
	rvc_pkg::fetch_word_u word_q[$];
	logic [31:0]          lcg_state = 32'd11;
	// the decoder side draws from its own sequence.
	logic [31:0]          credit_lcg = 32'd11;
	int                   up_credits;
	int                   owed;
	int                   received;

	`include "rvc_ref_model.svh"

	rvc_frontend u_dut (
		.clk          (clk),
		.rst          (rst),
		.fetch_valid  (fetch_valid),
		.fetch_word   (fetch_word),
		.issue_credit (issue_credit),
		.fetch_credit (fetch_credit),
		.issue_valid  (issue_valid),
		.issue_pkt    (issue_pkt)
	);

	bind rvc_frontend rvc_frontend_sva u_sva (
		.clk          (clk),
		.rst          (rst),
		.fetch_valid  (fetch_valid),
		.fetch_credit (fetch_credit),
		.issue_valid  (issue_valid),
		.issue_credit (issue_credit)
	);

	// only the upper halves of two LCG steps are used.
	function automatic logic [31:0] rand32(inout logic [31:0] state);
		logic [15:0] a;
		state = state * 32'd1664525 + 32'd1013904223;
		a = state[31:16];
		state = state * 32'd1664525 + 32'd1013904223;
		return {a, state[31:16]};
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	function automatic logic [15:0] kind_parcel(input int k, input logic [31:0] r);
		case (k)
			0: return {3'b000, r[12:2], 2'b00};
			1: return {3'b010, r[12:2], 2'b00};
			2: return {3'b110, r[12:2], 2'b00};
			3: return {3'b000, r[12:2], 2'b01};
			4: return {3'b001, r[12:2], 2'b01};
			5: return {3'b010, r[12:2], 2'b01};
			6: return {3'b011, r[12:2], 2'b01};
			7: return {6'b100000, r[9:2], 2'b01};
			8: return {6'b100001, r[9:2], 2'b01};
			9: return {3'b100, r[12], 2'b10, r[9:2], 2'b01};
			10: return {6'b100011, r[9:7], 2'b00, r[4:2], 2'b01};
			11: return {6'b100011, r[9:7], 2'b01, r[4:2], 2'b01};
			12: return {6'b100011, r[9:7], 2'b10, r[4:2], 2'b01};
			13: return {6'b100011, r[9:7], 2'b11, r[4:2], 2'b01};
			14: return {3'b101, r[12:2], 2'b01};
			15: return {3'b110, r[12:2], 2'b01};
			16: return {3'b111, r[12:2], 2'b01};
			17: return {4'b0000, r[11:2], 2'b10};
			18: return {3'b010, r[12:2], 2'b10};
			19: return {4'b1000, r[11:2], 2'b10};
			20: return {4'b1001, r[11:2], 2'b10};
			default: return {3'b110, r[12:2], 2'b10};
		endcase
	endfunction

	// zero, c.fld, an RV64 subw form and c.slli with shamt[5] set.
	function automatic logic [15:0] illegal_parcel(input int i);
		case (i % 4)
			0: return 16'h0000;
			1: return 16'h2000;
			2: return 16'h9c01;
			default: return 16'h1002;
		endcase
	endfunction

	task automatic build_program();
		logic [31:0] r;
		rvc_pkg::fetch_word_u w;
		for (int i = 0; i < 8; i++) begin
			add_wide(rand32(lcg_state) | 32'h3, "aligned_32bit");
		end
		for (int k = 0; k < 22; k++) begin
			add_short(kind_parcel(k, rand32(lcg_state)), "each_pattern");
		end
		add_short({3'b011, 1'b0, 5'd2, 5'b10110, 2'b01}, "addi16sp");
		add_short({4'b1000, 5'd5, 5'd0, 2'b10}, "c_jr");
		add_short({4'b1001, 5'd6, 5'd0, 2'b10}, "c_jalr");
		for (int i = 0; i < 4; i++) begin
			add_short(illegal_parcel(i), "illegal_parcel");
			add_wide(rand32(lcg_state) | 32'h3, "after_illegal");
		end
		for (int i = 0; i < 200; i++) begin
			r = rand32(lcg_state);
			if (r[2:0] < 3'd2) begin
				add_wide(rand32(lcg_state) | 32'h3, "mixed_stream");
			end else if (r[2:0] == 3'd2) begin
				add_short(illegal_parcel(int'(r[9:8])), "mixed_illegal");
			end else begin
				add_short(kind_parcel(int'(r[20:16]) % 22, rand32(lcg_state)),
					"mixed_stream");
			end
		end
		if (prog_q.size() % 2 != 0) begin
			add_short(16'h0001, "padding");
		end
		for (int i = 0; i < prog_q.size(); i += 2) begin
			w.half.lo = prog_q[i];
			w.half.hi = prog_q[i + 1];
			word_q.push_back(w);
		end
	endtask

	task automatic check_packet();
		rvc_pkg::issue_pkt_t exp;
		string name;
		assert (exp_q.size() != 0)
			else fail_now("a packet was issued after every instruction had been seen");
		exp = exp_q.pop_front();
		name = name_q.pop_front();
		assert (issue_pkt == exp)
			else fail_now($sformatf("** Error %s: expected %h actual %h", name, exp, issue_pkt));
		received++;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// upstream credit bookkeeping.
	always @(posedge clk) begin
		if (rst) begin
			up_credits <= rvc_pkg::FETCH_DEPTH;
		end else begin
			up_credits <= up_credits - (fetch_valid ? 1 : 0) + (fetch_credit ? 1 : 0);
		end
	end

	// ========================================================================
	// decoder side: scoreboard and random credit return
	// ========================================================================

	initial begin
		logic [31:0] r;
		owed = 0;
		received = 0;
		forever begin
			@(posedge clk);
			#1;
			r = rand32(credit_lcg);
			if (!rst) begin
				assert (up_credits <= rvc_pkg::FETCH_DEPTH)
					else fail_now("the frontend returned more fetch credits than were spent");
				if (issue_valid) begin
					check_packet();
					owed++;
				end
				if (owed > 0 && r[17]) begin
					issue_credit = 1'b1;
					owed--;
				end else begin
					issue_credit = 1'b0;
				end
			end
		end
	end

	initial begin
		int total;
		int t;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_word = '0;
		issue_credit = 1'b0;
		build_program();
		total = exp_q.size();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (word_q[i]) begin
			t = 0;
			while (up_credits == 0 || rand32(lcg_state) % 5 == 0) begin
				fetch_valid = 1'b0;
				@(posedge clk);
				#1;
				t++;
				if (t > 1000) begin
					fail_now("upstream waited too long for a fetch credit");
				end
			end
			fetch_valid = 1'b1;
			fetch_word = word_q[i];
			@(posedge clk);
			#1;
		end
		fetch_valid = 1'b0;
		t = 0;
		while (received < total || up_credits != rvc_pkg::FETCH_DEPTH) begin
			@(posedge clk);
			#1;
			t++;
			if (t > 5000) begin
				fail_now("stream did not drain: packets or fetch credits missing");
			end
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
src/rvc_pkg.sv
src/rvc_fetch_align.sv
src/rvc_decompress.sv
src/rvc_issue_credit.sv
src/rvc_frontend.sv
test/rvc_frontend_sva.sv
test/rvc_frontend_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the frontend testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rvc_frontend_tb -f vlog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vrvc_frontend_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
	exit 0
fi
exit 1
